//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = core_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = all tests passed

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/alu.sv
/*
 * Integer ALU
 * Executes one opcode per cycle and registers the result with its
 * destination as writeback
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module alu (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        op_valid,
    input  core_pkg::opcode_t           op,
    input  logic [`FULL_ADDR_WIDTH-1:0] dest,
    input  logic [`DATA_WIDTH-1:0]      imm,
    input  logic [`DATA_WIDTH-1:0]      operand_a,
    input  logic [`DATA_WIDTH-1:0]      operand_b,
    output logic                        wb_valid,
    output logic [`FULL_ADDR_WIDTH-1:0] wb_addr,
    output logic [`DATA_WIDTH-1:0]      wb_data
);

    import core_pkg::*;

    localparam int SHAMT_WIDTH = $clog2(`DATA_WIDTH);

    logic [`DATA_WIDTH-1:0] result;

    always_comb begin
        case (op)
            OP_ADD:  result = operand_a + operand_b;
            OP_SUB:  result = operand_a - operand_b;
            OP_AND:  result = operand_a & operand_b;
            OP_OR:   result = operand_a | operand_b;
            OP_XOR:  result = operand_a ^ operand_b;
            OP_SHL:  result = operand_a << operand_b[SHAMT_WIDTH-1:0];
            OP_LDI:  result = imm;
            default: result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Writeback register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= op_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (op_valid) begin
            wb_addr <= dest;
            wb_data <= result;
        end
    end

endmodule

//--- source/control_unit.sv
/*
 * Control unit
 * Run/done FSM, program counter and the per-instruction channel loop
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module control_unit (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      run,
    input  logic [`CH_ADDR_WIDTH:0]   n_channels,
    input  logic                      stop,
    output logic [`PC_WIDTH-1:0]      pc,
    output logic                      issue_valid,
    output logic [`CH_ADDR_WIDTH-1:0] channel,
    output logic                      busy,
    output logic                      done
);

    import core_pkg::*;

    localparam logic [`CH_ADDR_WIDTH:0] MAX_COUNT = (`CH_ADDR_WIDTH+1)'(`MAX_CHANNELS);

    ctrl_state_t             state;
    logic [`CH_ADDR_WIDTH:0] ch_count;
    logic                    drain_cnt;
    logic                    last_channel;

    assign busy        = (state != ST_IDLE);
    assign issue_valid = (state == ST_ISSUE);

    assign last_channel = ({1'b0, channel} == ch_count - 1'b1);

    //////////////////////////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= ST_IDLE;
            pc        <= '0;
            channel   <= '0;
            ch_count  <= '0;
            drain_cnt <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (run) begin
                        pc      <= '0;
                        channel <= '0;
                        // Out of range counts are clamped to a legal value
                        if (n_channels == '0) begin
                            ch_count <= {{`CH_ADDR_WIDTH{1'b0}}, 1'b1};
                        end else if (n_channels > MAX_COUNT) begin
                            ch_count <= MAX_COUNT;
                        end else begin
                            ch_count <= n_channels;
                        end
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    state <= ST_ISSUE;
                end
                ST_ISSUE: begin
                    if (stop) begin
                        channel   <= '0;
                        drain_cnt <= 1'b0;
                        state     <= ST_DRAIN;
                    end else if (last_channel) begin
                        channel <= '0;
                        pc      <= pc + 1'b1;
                        state   <= ST_FETCH;
                    end else begin
                        channel <= channel + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    // Two cycles let the last writeback land
                    drain_cnt <= 1'b1;
                    if (drain_cnt) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/core_defs.svh
/*
 * Core configuration
 * Datapath and register file sizes, channel count, instruction store depth
 * and the bit positions of the instruction fields
 */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath
`define DATA_WIDTH      32

// Registers per channel and channelised register file
`define REG_DEPTH       16
`define REG_ADDR_WIDTH  4
`define MAX_CHANNELS    4
`define CH_ADDR_WIDTH   2
`define FULL_ADDR_WIDTH 6
`define REG_FILE_SIZE   (`MAX_CHANNELS * `REG_DEPTH)

// Instruction store
`define STORE_DEPTH     64
`define PC_WIDTH        6
`define INSTR_WIDTH     32

// Instruction fields
`define OPCODE_MSB      31
`define OPCODE_LSB      28
`define DEST_MSB        27
`define DEST_LSB        24
`define SRC_A_MSB       23
`define SRC_A_LSB       20
`define SRC_B_MSB       19
`define SRC_B_LSB       16
`define IMM_MSB         15
`define IMM_LSB         0
`define IMM_WIDTH       16

`endif

//--- source/core_pkg.sv
/*
 * Core types
 * Opcode encoding and control FSM states
 */
package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Opcodes, held in the top nibble of the instruction word
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        // Shift amount from the low five bits of operand b
        OP_SHL  = 4'h6,
        // Zero-extended 16-bit immediate
        OP_LDI  = 4'h7,
        OP_STOP = 4'hF
    } opcode_t;

    //////////////////////////////////////////////////////////////////////
    // Control unit states
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FETCH = 2'd1,
        ST_ISSUE = 2'd2,
        ST_DRAIN = 2'd3
    } ctrl_state_t;

endpackage

//--- source/core_top.sv
/*
 * Channelised integer core
 * Connects the store, control unit, decoder, register file and ALU
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module core_top (
    input  logic                        clock,
    input  logic                        rst,
    // Program load
    input  logic                        prog_valid,
    input  logic [`PC_WIDTH-1:0]        prog_addr,
    input  logic [`INSTR_WIDTH-1:0]     prog_data,
    // Register access
    input  logic                        dma_valid,
    input  logic                        dma_write,
    input  logic [`FULL_ADDR_WIDTH-1:0] dma_addr,
    input  logic [`DATA_WIDTH-1:0]      dma_wdata,
    output logic                        dma_ready,
    output logic                        dma_rvalid,
    output logic [`DATA_WIDTH-1:0]      dma_rdata,
    // Run control
    input  logic                        run,
    input  logic [`CH_ADDR_WIDTH:0]     n_channels,
    output logic                        busy,
    output logic                        done
);

    import core_pkg::*;

    logic [`PC_WIDTH-1:0]        pc;
    logic [`INSTR_WIDTH-1:0]     instr;
    logic                        issue_valid;
    logic [`CH_ADDR_WIDTH-1:0]   channel;
    logic                        stop;
    logic [`FULL_ADDR_WIDTH-1:0] read_addr_a;
    logic [`FULL_ADDR_WIDTH-1:0] read_addr_b;
    logic [`DATA_WIDTH-1:0]      read_data_a;
    logic [`DATA_WIDTH-1:0]      read_data_b;
    logic                        op_valid;
    opcode_t                     op;
    logic [`FULL_ADDR_WIDTH-1:0] dest;
    logic [`DATA_WIDTH-1:0]      imm;
    logic                        wb_valid;
    logic [`FULL_ADDR_WIDTH-1:0] wb_addr;
    logic [`DATA_WIDTH-1:0]      wb_data;

    // Program writes are ignored while a run is in progress
    wire prog_write = prog_valid & ~busy;

    instruction_store instruction_store_inst (
        .clock      (clock),
        .prog_valid (prog_write),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .pc         (pc),
        .instr      (instr)
    );

    control_unit control_unit_inst (
        .clock       (clock),
        .rst         (rst),
        .run         (run),
        .n_channels  (n_channels),
        .stop        (stop),
        .pc          (pc),
        .issue_valid (issue_valid),
        .channel     (channel),
        .busy        (busy),
        .done        (done)
    );

    decoder decoder_inst (
        .clock       (clock),
        .rst         (rst),
        .instr       (instr),
        .issue_valid (issue_valid),
        .channel     (channel),
        .stop        (stop),
        .read_addr_a (read_addr_a),
        .read_addr_b (read_addr_b),
        .op_valid    (op_valid),
        .op          (op),
        .dest        (dest),
        .imm         (imm)
    );

    register_file register_file_inst (
        .clock       (clock),
        .rst         (rst),
        .read_addr_a (read_addr_a),
        .read_data_a (read_data_a),
        .read_addr_b (read_addr_b),
        .read_data_b (read_data_b),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .dma_valid   (dma_valid),
        .dma_write   (dma_write),
        .dma_addr    (dma_addr),
        .dma_wdata   (dma_wdata),
        .busy        (busy),
        .dma_ready   (dma_ready),
        .dma_rvalid  (dma_rvalid),
        .dma_rdata   (dma_rdata)
    );

    alu alu_inst (
        .clock     (clock),
        .rst       (rst),
        .op_valid  (op_valid),
        .op        (op),
        .dest      (dest),
        .imm       (imm),
        .operand_a (read_data_a),
        .operand_b (read_data_b),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

endmodule

//--- source/decoder.sv
/*
 * Instruction decoder
 * Splits the instruction into fields, prefixes the channel to each register
 * index and issues one aligned operation per channel
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module decoder (
    input  logic                        clock,
    input  logic                        rst,
    input  logic [`INSTR_WIDTH-1:0]     instr,
    input  logic                        issue_valid,
    input  logic [`CH_ADDR_WIDTH-1:0]   channel,
    output logic                        stop,
    output logic [`FULL_ADDR_WIDTH-1:0] read_addr_a,
    output logic [`FULL_ADDR_WIDTH-1:0] read_addr_b,
    output logic                        op_valid,
    output core_pkg::opcode_t           op,
    output logic [`FULL_ADDR_WIDTH-1:0] dest,
    output logic [`DATA_WIDTH-1:0]      imm
);

    import core_pkg::*;

    opcode_t                    opcode;
    logic                       writes_reg;
    logic [`REG_ADDR_WIDTH-1:0] src_a_q;
    logic [`REG_ADDR_WIDTH-1:0] src_b_q;
    logic [`CH_ADDR_WIDTH-1:0]  channel_q;

    assign opcode = opcode_t'(instr[`OPCODE_MSB:`OPCODE_LSB]);
    assign stop   = issue_valid && (opcode == OP_STOP);

    // Only these opcodes produce a writeback, unknown codes act as NOP
    always_comb begin
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_LDI: writes_reg = 1'b1;
            default: writes_reg = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Issue stage register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= issue_valid && writes_reg;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            op        <= opcode;
            dest      <= {channel, instr[`DEST_MSB:`DEST_LSB]};
            imm       <= {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, instr[`IMM_MSB:`IMM_LSB]};
            src_a_q   <= instr[`SRC_A_MSB:`SRC_A_LSB];
            src_b_q   <= instr[`SRC_B_MSB:`SRC_B_LSB];
            channel_q <= channel;
        end
    end

    // Operand addresses come from the same stage as op, so data lines up
    assign read_addr_a = {channel_q, src_a_q};
    assign read_addr_b = {channel_q, src_b_q};

endmodule

//--- source/instruction_store.sv
/*
 * Instruction store
 * Program memory loaded by the host, read by the control unit through a
 * registered port with one cycle of latency
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module instruction_store (
    input  logic                    clock,
    input  logic                    prog_valid,
    input  logic [`PC_WIDTH-1:0]    prog_addr,
    input  logic [`INSTR_WIDTH-1:0] prog_data,
    input  logic [`PC_WIDTH-1:0]    pc,
    output logic [`INSTR_WIDTH-1:0] instr
);

    logic [`INSTR_WIDTH-1:0] mem [`STORE_DEPTH];

    // Host write port
    always_ff @(posedge clock) begin
        if (prog_valid) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Fetch port, pc presented in FETCH gives instr in ISSUE
    always_ff @(posedge clock) begin
        instr <= mem[pc];
    end

endmodule

//--- source/register_file.sv
/*
 * Channelised register file
 * Two asynchronous operand reads, ALU writeback and a host access port
 * that is open only while the core is idle
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module register_file (
    input  logic                        clock,
    input  logic                        rst,
    input  logic [`FULL_ADDR_WIDTH-1:0] read_addr_a,
    output logic [`DATA_WIDTH-1:0]      read_data_a,
    input  logic [`FULL_ADDR_WIDTH-1:0] read_addr_b,
    output logic [`DATA_WIDTH-1:0]      read_data_b,
    input  logic                        wb_valid,
    input  logic [`FULL_ADDR_WIDTH-1:0] wb_addr,
    input  logic [`DATA_WIDTH-1:0]      wb_data,
    input  logic                        dma_valid,
    input  logic                        dma_write,
    input  logic [`FULL_ADDR_WIDTH-1:0] dma_addr,
    input  logic [`DATA_WIDTH-1:0]      dma_wdata,
    input  logic                        busy,
    output logic                        dma_ready,
    output logic                        dma_rvalid,
    output logic [`DATA_WIDTH-1:0]      dma_rdata
);

    logic [`DATA_WIDTH-1:0] regs [`REG_FILE_SIZE];
    logic                   dma_accept;

    assign dma_ready  = !busy;
    assign dma_accept = dma_valid && dma_ready;

    // Operand reads
    assign read_data_a = regs[read_addr_a];
    assign read_data_b = regs[read_addr_b];

    //////////////////////////////////////////////////////////////////////
    // Write ports, writeback first
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `REG_FILE_SIZE; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_addr] <= wb_data;
        end else if (dma_accept && dma_write) begin
            regs[dma_addr] <= dma_wdata;
        end
    end

    // Host read response
    always_ff @(posedge clock) begin
        if (rst) begin
            dma_rvalid <= 1'b0;
        end else begin
            dma_rvalid <= dma_accept && !dma_write;
        end
    end

    always_ff @(posedge clock) begin
        if (dma_accept && !dma_write) begin
            dma_rdata <= regs[dma_addr];
        end
    end

endmodule

//--- verif/core_sva.sv
/*
 * Core protocol assertions
 * Done pulse width, host port gating and read response timing
 */
`timescale 1ns/10ps

module core_sva (
    input logic clock,
    input logic rst,
    input logic busy,
    input logic done,
    input logic dma_valid,
    input logic dma_write,
    input logic dma_ready,
    input logic dma_rvalid
);

    // Single-cycle done pulse
    done_pulse_a: assert property (@(posedge clock) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Host port closed for the whole run
    ready_gate_a: assert property (@(posedge clock) disable iff (rst) !(dma_ready && busy))
        else $error("dma_ready high while busy");

    read_resp_a: assert property (@(posedge clock) disable iff (rst)
                                  (dma_valid && dma_ready && !dma_write) |=> dma_rvalid)
        else $error("dma_rvalid missing one cycle after an accepted read");

    reset_done_a: assert property (@(posedge clock) rst |=> !done)
        else $error("done high during reset");

endmodule

bind core_top core_sva core_sva_inst (.*);

//--- verif/core_tb.sv
/*
 * Directed testbench for the channelised core
 * Loads programs and registers through the host ports, runs them and
 * checks every register against a model of the opcode rules
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module core_tb;

    import core_pkg::*;

    localparam int TIMEOUT_CYCLES = 500;

    logic                        clock;
    logic                        rst;
    logic                        prog_valid;
    logic [`PC_WIDTH-1:0]        prog_addr;
    logic [`INSTR_WIDTH-1:0]     prog_data;
    logic                        dma_valid;
    logic                        dma_write;
    logic [`FULL_ADDR_WIDTH-1:0] dma_addr;
    logic [`DATA_WIDTH-1:0]      dma_wdata;
    logic                        dma_ready;
    logic                        dma_rvalid;
    logic [`DATA_WIDTH-1:0]      dma_rdata;
    logic                        run;
    logic [`CH_ADDR_WIDTH:0]     n_channels;
    logic                        busy;
    logic                        done;

    // Expected register contents and the program under test
    logic [`DATA_WIDTH-1:0]  model [`REG_FILE_SIZE];
    logic [`INSTR_WIDTH-1:0] prog_q [$];
    integer                  seed;

    core_top core_top_inst (.*);

    always #5 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Reporting and compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_data(input logic [`DATA_WIDTH-1:0] actual,
                              input logic [`DATA_WIDTH-1:0] expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("[FAIL] %0t %s: got %h, expected %h",
                                     $time, what, actual, expected));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("[FAIL] %0t %s: got %b, expected %b",
                                     $time, what, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host port helpers entered and left 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    function automatic logic [`FULL_ADDR_WIDTH-1:0] reg_addr(input int ch, input int r);
        return {ch[`CH_ADDR_WIDTH-1:0], r[`REG_ADDR_WIDTH-1:0]};
    endfunction

    function automatic logic [`INSTR_WIDTH-1:0] make_instr(input opcode_t op, input int d,
                                                           input int a, input int b,
                                                           input int imm);
        logic [`INSTR_WIDTH-1:0] w;
        w = '0;
        w[`OPCODE_MSB:`OPCODE_LSB] = op;
        w[`DEST_MSB:`DEST_LSB]     = d[`REG_ADDR_WIDTH-1:0];
        w[`SRC_A_MSB:`SRC_A_LSB]   = a[`REG_ADDR_WIDTH-1:0];
        w[`SRC_B_MSB:`SRC_B_LSB]   = b[`REG_ADDR_WIDTH-1:0];
        w[`IMM_MSB:`IMM_LSB]       = imm[`IMM_WIDTH-1:0];
        return w;
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        while (!dma_ready) begin
            next_cycle();
            n++;
            if (n > TIMEOUT_CYCLES) report_failure("Timed out waiting for dma_ready");
        end
    endtask

    task automatic write_reg(input logic [`FULL_ADDR_WIDTH-1:0] addr,
                             input logic [`DATA_WIDTH-1:0] data);
        dma_valid = 1'b1;
        dma_write = 1'b1;
        dma_addr  = addr;
        dma_wdata = data;
        wait_ready();
        next_cycle();
        dma_valid = 1'b0;
        dma_write = 1'b0;
        model[addr] = data;
    endtask

    task automatic read_reg(input logic [`FULL_ADDR_WIDTH-1:0] addr,
                            output logic [`DATA_WIDTH-1:0] data);
        int n;
        dma_valid = 1'b1;
        dma_write = 1'b0;
        dma_addr  = addr;
        wait_ready();
        next_cycle();
        dma_valid = 1'b0;
        n = 0;
        while (!dma_rvalid) begin
            next_cycle();
            n++;
            if (n > TIMEOUT_CYCLES) report_failure("Timed out waiting for dma_rvalid");
        end
        data = dma_rdata;
    endtask

    task automatic check_reg(input logic [`FULL_ADDR_WIDTH-1:0] addr);
        logic [`DATA_WIDTH-1:0] data;
        read_reg(addr, data);
        check_data(data, model[addr], $sformatf("channel %0d register %0d",
                                                addr[5:4], addr[3:0]));
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < `REG_FILE_SIZE; i++) begin
            check_reg(i[`FULL_ADDR_WIDTH-1:0]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program load, reference model and run control
    //////////////////////////////////////////////////////////////////////
    task automatic load_program();
        foreach (prog_q[i]) begin
            prog_valid = 1'b1;
            prog_addr  = i[`PC_WIDTH-1:0];
            prog_data  = prog_q[i];
            next_cycle();
        end
        prog_valid = 1'b0;
    endtask

    // Executes the program in order, every instruction once per channel
    task automatic apply_model(input int n);
        opcode_t                     op;
        logic [`INSTR_WIDTH-1:0]     w;
        logic [`FULL_ADDR_WIDTH-1:0] d;
        logic [`DATA_WIDTH-1:0]      va;
        logic [`DATA_WIDTH-1:0]      vb;
        foreach (prog_q[i]) begin
            w  = prog_q[i];
            op = opcode_t'(w[`OPCODE_MSB:`OPCODE_LSB]);
            if (op == OP_STOP) break;
            for (int c = 0; c < n; c++) begin
                d  = reg_addr(c, int'(w[`DEST_MSB:`DEST_LSB]));
                va = model[reg_addr(c, int'(w[`SRC_A_MSB:`SRC_A_LSB]))];
                vb = model[reg_addr(c, int'(w[`SRC_B_MSB:`SRC_B_LSB]))];
                case (op)
                    OP_ADD:  model[d] = va + vb;
                    OP_SUB:  model[d] = va - vb;
                    OP_AND:  model[d] = va & vb;
                    OP_OR:   model[d] = va | vb;
                    OP_XOR:  model[d] = va ^ vb;
                    OP_SHL:  model[d] = va << vb[4:0];
                    OP_LDI:  model[d] = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, w[`IMM_MSB:`IMM_LSB]};
                    default: ;
                endcase
            end
        end
    endtask

    task automatic start_run(input int n);
        run        = 1'b1;
        n_channels = n[`CH_ADDR_WIDTH:0];
        next_cycle();
        run = 1'b0;
        check_flag(busy, 1'b1, "busy after run");
        check_flag(dma_ready, 1'b0, "dma_ready while busy");
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done) begin
            check_flag(dma_ready, 1'b0, "dma_ready while busy");
            next_cycle();
            n++;
            if (n > TIMEOUT_CYCLES) report_failure("Timed out waiting for done");
        end
        check_flag(busy, 1'b0, "busy in the done cycle");
        next_cycle();
        check_flag(done, 1'b0, "done one cycle after the pulse");
    endtask

    task automatic run_program(input int n);
        load_program();
        apply_model(n);
        start_run(n);
        wait_done();
        check_all_regs();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_reset();
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(dma_rvalid, 1'b0, "dma_rvalid after reset");
        check_flag(dma_ready, 1'b1, "dma_ready after reset");
        check_all_regs();
    endtask

    task automatic test_register_access();
        logic [`DATA_WIDTH-1:0] v;
        for (int i = 0; i < `REG_FILE_SIZE; i++) begin
            v = 32'hC0DE_0000 + 32'(i) * 32'h0001_0101;
            write_reg(i[`FULL_ADDR_WIDTH-1:0], v);
        end
        check_all_regs();
        // Read straight after a write
        write_reg(reg_addr(2, 7), 32'h1234_5678);
        check_reg(reg_addr(2, 7));
    endtask

    task automatic test_single_channel();
        prog_q.delete();
        prog_q.push_back(make_instr(OP_LDI, 1, 0, 0, 'h1234));
        prog_q.push_back(make_instr(OP_LDI, 2, 0, 0, 'h00F0));
        // Shift amount with bits set above the low five
        prog_q.push_back(make_instr(OP_LDI, 3, 0, 0, 'h0025));
        prog_q.push_back(make_instr(OP_LDI, 11, 0, 0, 'hFFFF));
        prog_q.push_back(make_instr(OP_NOP, 0, 0, 0, 0));
        prog_q.push_back(make_instr(OP_ADD, 4, 1, 2, 0));
        prog_q.push_back(make_instr(OP_SUB, 5, 2, 1, 0));
        prog_q.push_back(make_instr(OP_AND, 6, 1, 2, 0));
        prog_q.push_back(make_instr(OP_OR, 7, 1, 2, 0));
        prog_q.push_back(make_instr(OP_XOR, 8, 1, 2, 0));
        prog_q.push_back(make_instr(OP_SHL, 9, 1, 3, 0));
        prog_q.push_back(make_instr(OP_NOP, 0, 0, 0, 0));
        prog_q.push_back(make_instr(OP_ADD, 10, 4, 5, 0));
        prog_q.push_back(make_instr(OP_STOP, 0, 0, 0, 0));
        run_program(1);
    endtask

    task automatic test_multi_channel();
        logic [`DATA_WIDTH-1:0] cv;
        for (int c = 0; c < `MAX_CHANNELS; c++) begin
            cv = 32'(c);
            write_reg(reg_addr(c, 1), 32'h0100_0000 * (cv + 1) + 32'h55);
            write_reg(reg_addr(c, 2), 32'hF0F0_0F0F >> cv);
        end
        prog_q.delete();
        prog_q.push_back(make_instr(OP_ADD, 3, 1, 2, 0));
        prog_q.push_back(make_instr(OP_XOR, 4, 1, 2, 0));
        prog_q.push_back(make_instr(OP_NOP, 0, 0, 0, 0));
        prog_q.push_back(make_instr(OP_ADD, 5, 3, 4, 0));
        prog_q.push_back(make_instr(OP_STOP, 0, 0, 0, 0));
        run_program(3);
    endtask

    // A host read posted during the run must wait and finish after done
    task automatic test_run_control();
        int                          cycles;
        int                          done_count;
        logic                        accept;
        logic [`FULL_ADDR_WIDTH-1:0] addr;
        addr = reg_addr(2, 2);
        prog_q.delete();
        prog_q.push_back(make_instr(OP_LDI, 0, 0, 0, 'hBEEF));
        prog_q.push_back(make_instr(OP_LDI, 1, 0, 0, 'h1357));
        prog_q.push_back(make_instr(OP_NOP, 0, 0, 0, 0));
        prog_q.push_back(make_instr(OP_ADD, 2, 0, 1, 0));
        prog_q.push_back(make_instr(OP_STOP, 0, 0, 0, 0));
        load_program();
        apply_model(4);
        start_run(4);
        dma_valid  = 1'b1;
        dma_write  = 1'b0;
        dma_addr   = addr;
        cycles     = 0;
        done_count = 0;
        while (!dma_rvalid) begin
            if (busy) check_flag(dma_ready, 1'b0, "dma_ready while busy");
            if (done) begin
                done_count++;
                check_flag(busy, 1'b0, "busy in the done cycle");
            end
            accept = dma_valid && dma_ready;
            next_cycle();
            if (accept) dma_valid = 1'b0;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) report_failure("Timed out waiting for the held read");
        end
        check_flag(done_count == 1, 1'b1, "one done pulse before the read data");
        check_data(dma_rdata, model[addr], "read held during the run");
        repeat (4) begin
            next_cycle();
            check_flag(done, 1'b0, "done after the run");
        end
        check_all_regs();
    endtask

    task automatic test_random_operands();
        opcode_t op;
        for (int c = 0; c < `MAX_CHANNELS; c++) begin
            for (int r = 0; r < `REG_DEPTH; r++) begin
                write_reg(reg_addr(c, r), $random(seed));
            end
        end
        prog_q.delete();
        for (int k = 0; k < 8; k++) begin
            op = (k % 3 == 0) ? OP_ADD : ((k % 3 == 1) ? OP_SUB : OP_XOR);
            prog_q.push_back(make_instr(op, 2 * k, 2 * k, 2 * k + 1, 0));
        end
        prog_q.push_back(make_instr(OP_STOP, 0, 0, 0, 0));
        run_program(4);
    endtask

    initial begin
        clock      = 1'b0;
        rst        = 1'b1;
        prog_valid = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        dma_valid  = 1'b0;
        dma_write  = 1'b0;
        dma_addr   = '0;
        dma_wdata  = '0;
        run        = 1'b0;
        n_channels = '0;
        seed       = 32'hde85dc54;
        for (int i = 0; i < `REG_FILE_SIZE; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clock);
        #1;
        rst = 1'b0;

        test_reset();
        test_register_access();
        test_single_channel();
        test_multi_channel();
        test_run_control();
        test_random_operands();

        $display("all tests passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/core_pkg.sv
source/instruction_store.sv
source/control_unit.sv
source/decoder.sv
source/register_file.sv
source/alu.sv
source/core_top.sv
verif/core_sva.sv
verif/core_tb.sv
